/* logic/mulPkg.sv */
package mulPkg;

    // Operation encoding follows funct3 of the RISC-V M extension multiplies
    typedef enum logic [1:0] {
        MUL    = 2'd0,  // Low word, sign does not matter
        MULH   = 2'd1,  // High word, both operands signed
        MULHSU = 2'd2,  // High word, op1 signed and op2 unsigned
        MULHU  = 2'd3   // High word, both operands unsigned
    } mulOp_t;

    localparam int OperandWidth = 32;
    localparam int ProductWidth = 2 * OperandWidth;  // Full product before word select

endpackage

/* logic/operandPrep.sv */
`timescale 1ns/100ps

module operandPrep (
    input  logic                            clk,
    input  logic [mulPkg::OperandWidth-1:0] op1,
    input  logic [mulPkg::OperandWidth-1:0] op2,
    input  logic                            op1Signed,
    input  logic                            op2Signed,
    output logic [mulPkg::OperandWidth-1:0] magA,
    output logic [mulPkg::OperandWidth-1:0] magB,
    output logic                            negate
);

    import mulPkg::*;

    logic                    op1Neg;
    logic                    op2Neg;
    logic [OperandWidth-1:0] op1Mag;
    logic [OperandWidth-1:0] op2Mag;

    // A sign bit only counts when the operation treats that operand as signed
    assign op1Neg = op1Signed & op1[OperandWidth-1];
    assign op2Neg = op2Signed & op2[OperandWidth-1];

    // The most negative value maps to 2^31, which still fits as an unsigned magnitude
    assign op1Mag = op1Neg ? -op1 : op1;
    assign op2Mag = op2Neg ? -op2 : op2;

    always_ff @(posedge clk) begin
        magA   <= op1Mag;
        magB   <= op2Mag;
        negate <= op1Neg ^ op2Neg;  // Sign of the final product
    end

endmodule

/* logic/wallaceTree.sv */
`timescale 1ns/100ps

module wallaceTree (
    input  logic                            clk,
    input  logic [mulPkg::OperandWidth-1:0] magA,
    input  logic [mulPkg::OperandWidth-1:0] magB,
    output logic [mulPkg::ProductWidth-1:0] sumVec,
    output logic [mulPkg::ProductWidth-1:0] carryVec
);

    import mulPkg::*;

    localparam int numLevels   = 8;
    localparam int numPartials = OperandWidth;

    // Number of 3:2 rows per level, each row turns three vectors into two
    localparam int rowCount [numLevels] = '{10, 7, 5, 3, 2, 1, 1, 1};

    // Vectors entering a level: 32, 22, 15, 10, 7, 5, 4, 3 and finally 2
    function automatic int levelSize(input int level);
        int size;
        size = numPartials;
        for (int k = 0; k < level; k++) begin
            size = size - rowCount[k];
        end
        return size;
    endfunction

    // All levels share one flat vector array, each level starts here
    function automatic int levelBase(input int level);
        int base;
        base = 0;
        for (int k = 0; k < level; k++) begin
            base = base + levelSize(k);
        end
        return base;
    endfunction

    localparam int numVectors = levelBase(numLevels + 1);
    localparam int finalBase  = levelBase(numLevels);

    logic [ProductWidth-1:0] magAWide;
    logic [ProductWidth-1:0] vec [numVectors];

    assign magAWide = {{(ProductWidth - OperandWidth){1'b0}}, magA};

    for (genvar i = 0; i < numPartials; i++) begin : gPartial
        assign vec[i] = magB[i] ? (magAWide << i) : '0;  // Row i of the schoolbook product
    end

    for (genvar l = 0; l < numLevels; l++) begin : gLevel
        localparam int inBase    = levelBase(l);
        localparam int outBase   = levelBase(l + 1);
        localparam int rows      = rowCount[l];
        localparam int passCount = levelSize(l) - 3 * rows;

        for (genvar r = 0; r < rows; r++) begin : gRow
            logic [ProductWidth-1:0] x;
            logic [ProductWidth-1:0] y;
            logic [ProductWidth-1:0] z;
            logic [ProductWidth-1:0] majority;

            assign x        = vec[inBase + 3 * r];
            assign y        = vec[inBase + 3 * r + 1];
            assign z        = vec[inBase + 3 * r + 2];
            assign majority = (x & y) | (x & z) | (y & z);

            assign vec[outBase + 2 * r]     = x ^ y ^ z;
            // Carry has the weight of the next bit up
            assign vec[outBase + 2 * r + 1] = {majority[ProductWidth-2:0], 1'b0};
        end

        // Vectors left over after the rows move on to the next level untouched
        for (genvar j = 0; j < passCount; j++) begin : gPass
            assign vec[outBase + 2 * rows + j] = vec[inBase + 3 * rows + j];
        end
    end

    always_ff @(posedge clk) begin
        sumVec   <= vec[finalBase];
        carryVec <= vec[finalBase + 1];
    end

endmodule

/* logic/lookaheadAdder.sv */
`timescale 1ns/100ps

module lookaheadAdder #(
    parameter int groupWidth = 4
) (
    input  logic [mulPkg::ProductWidth-1:0] a,
    input  logic [mulPkg::ProductWidth-1:0] b,
    output logic [mulPkg::ProductWidth-1:0] sum
);

    import mulPkg::*;

    localparam int numGroups = ProductWidth / groupWidth;

    logic [ProductWidth-1:0] gen;
    logic [ProductWidth-1:0] prop;
    logic [ProductWidth-1:0] carry;
    logic [numGroups-1:0]    groupGen;
    logic [numGroups-1:0]    groupProp;
    logic [numGroups-1:0]    groupCarry;

    assign gen  = a & b;
    assign prop = a ^ b;

    always_comb begin  // Group generate and propagate terms
        logic genAcc;
        logic propAcc;
        for (int k = 0; k < numGroups; k++) begin
            genAcc  = 1'b0;
            propAcc = 1'b1;
            for (int i = 0; i < groupWidth; i++) begin
                genAcc  = gen[k * groupWidth + i] | (prop[k * groupWidth + i] & genAcc);
                propAcc = propAcc & prop[k * groupWidth + i];
            end
            groupGen[k]  = genAcc;
            groupProp[k] = propAcc;
        end
    end

    always_comb begin  // Lookahead across groups, carry-out of the top group is dropped
        logic c;
        c = 1'b0;
        for (int k = 0; k < numGroups; k++) begin
            groupCarry[k] = c;
            c = groupGen[k] | (groupProp[k] & c);
        end
    end

    always_comb begin  // Bit carries inside each group start from the group carry-in
        logic c;
        for (int k = 0; k < numGroups; k++) begin
            c = groupCarry[k];
            for (int i = 0; i < groupWidth; i++) begin
                carry[k * groupWidth + i] = c;
                c = gen[k * groupWidth + i] | (prop[k * groupWidth + i] & c);
            end
        end
    end

    assign sum = prop ^ carry;

endmodule

/* logic/productFixup.sv */
`timescale 1ns/100ps

module productFixup #(
    parameter int groupWidth = 4
) (
    input  logic                            clk,
    input  logic [mulPkg::ProductWidth-1:0] sumVec,
    input  logic [mulPkg::ProductWidth-1:0] carryVec,
    input  logic                            negateS2,
    input  logic                            selectHigh,
    output logic [mulPkg::OperandWidth-1:0] result
);

    import mulPkg::*;

    logic [ProductWidth-1:0] magProduct;
    logic [ProductWidth-1:0] product;
    logic [OperandWidth-1:0] word;

    lookaheadAdder #(
        .groupWidth(groupWidth)
    ) adder_i (
        .a  (sumVec),
        .b  (carryVec),
        .sum(magProduct)
    );

    // Two's complement of the whole 64-bit product so the high word is right too
    assign product = negateS2 ? -magProduct : magProduct;

    assign word = selectHigh ? product[ProductWidth-1:OperandWidth]
                             : product[OperandWidth-1:0];

    always_ff @(posedge clk) begin
        result <= word;
    end

endmodule

/* logic/mulControl.sv */
`timescale 1ns/100ps

module mulControl (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  mulPkg::mulOp_t op,
    input  logic           negate,
    output logic           op1Signed,
    output logic           op2Signed,
    output logic           negateS2,
    output logic           selectHigh,
    output logic           done
);

    import mulPkg::*;

    localparam int numStages = 3;

    logic [numStages-1:0] validPipe;
    logic                 highS1;
    logic                 highS2;

    // MULHSU treats only op1 as signed, MUL needs no sign handling for its low word
    assign op1Signed = (op == MULH) || (op == MULHSU);
    assign op2Signed = (op == MULH);

    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[numStages-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        highS1   <= (op != MUL);
        highS2   <= highS1;  // Lines up with the sum/carry pair
        negateS2 <= negate;
    end

    assign selectHigh = highS2;
    assign done       = validPipe[numStages-1];

endmodule

/* logic/mulUnit.sv */
`timescale 1ns/100ps

module mulUnit #(
    parameter int groupWidth = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  mulPkg::mulOp_t                  op,
    input  logic [mulPkg::OperandWidth-1:0] op1,
    input  logic [mulPkg::OperandWidth-1:0] op2,
    output logic                            done,
    output logic [mulPkg::OperandWidth-1:0] result
);

    import mulPkg::*;

    logic                    op1Signed;
    logic                    op2Signed;
    logic                    negate;
    logic                    negateS2;
    logic                    selectHigh;
    logic [OperandWidth-1:0] magA;
    logic [OperandWidth-1:0] magB;
    logic [ProductWidth-1:0] sumVec;
    logic [ProductWidth-1:0] carryVec;

    mulControl control_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .op        (op),
        .negate    (negate),
        .op1Signed (op1Signed),
        .op2Signed (op2Signed),
        .negateS2  (negateS2),
        .selectHigh(selectHigh),
        .done      (done)
    );

    operandPrep prep_i (
        .clk      (clk),
        .op1      (op1),
        .op2      (op2),
        .op1Signed(op1Signed),
        .op2Signed(op2Signed),
        .magA     (magA),
        .magB     (magB),
        .negate   (negate)
    );

    wallaceTree tree_i (
        .clk     (clk),
        .magA    (magA),
        .magB    (magB),
        .sumVec  (sumVec),
        .carryVec(carryVec)
    );

    productFixup #(
        .groupWidth(groupWidth)
    ) fixup_i (
        .clk       (clk),
        .sumVec    (sumVec),
        .carryVec  (carryVec),
        .negateS2  (negateS2),
        .selectHigh(selectHigh),
        .result    (result)
    );

endmodule

/* verif/mulUnitTb.sv */
`timescale 1ns/100ps

module mulUnitTb #(
    parameter int groupWidth = 4
);

    import mulPkg::*;

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 8;
    localparam int quietCycles = 10;
    localparam int latency     = 3;   // Cycles from the start cycle to the done cycle
    localparam int numCorners  = 7;
    localparam int randomPairs = 50;
    localparam int numMixed    = 4;
    localparam int mixedRandom = 16;
    localparam int streamOps   = 100;
    localparam int gapOps      = 20;
    localparam int drainLimit  = 6;
    localparam int tailCycles  = 5;   // Idle time after the stream to catch stray done strobes

    localparam logic [31:0] lcgSeed = 32'hcc03adef;

    localparam logic [OperandWidth-1:0] corners [numCorners] = '{
        32'h00000000, 32'h00000001, 32'hffffffff, 32'h80000000,
        32'h7fffffff, 32'haaaaaaaa, 32'h55555555
    };

    // Negative when read as signed
    localparam logic [OperandWidth-1:0] negOperands [numMixed] = '{
        32'hffffffff, 32'h80000000, 32'hfffffff6, 32'hc0000000
    };

    localparam logic [OperandWidth-1:0] bigOperands [numMixed] = '{
        32'hffffffff, 32'h80000000, 32'h00000003, 32'hdeadbeef
    };

    // Idle cycles inserted by the gap pattern of the streaming test
    function automatic int gapIdleTotal();
        int total;
        total = 0;
        for (int i = 0; i < gapOps; i++) begin
            total += i % 3;
        end
        return total;
    endfunction

    localparam int productOps = numCorners * numCorners + randomPairs;
    localparam int mixedOps   = 2 * (numMixed * numMixed + mixedRandom);
    localparam int runCycles  = resetCycles + quietCycles + 2 * productOps + mixedOps
                              + streamOps + gapOps + gapIdleTotal() + tailCycles
                              + 4 * drainLimit;
    localparam int watchdogCycles = runCycles + 20;

    logic                    clk;
    logic                    reset;
    logic                    start;
    mulOp_t                  op;
    logic [OperandWidth-1:0] op1;
    logic [OperandWidth-1:0] op2;
    logic                    done;
    logic [OperandWidth-1:0] result;

    logic [31:0]             lcgState;
    int                      cycle = 0;
    logic [OperandWidth-1:0] expQueue [$];
    int                      issueQueue [$];
    string                   descQueue [$];

    mulUnit #(
        .groupWidth(groupWidth)
    ) dut_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .op    (op),
        .op1   (op1),
        .op2   (op2),
        .done  (done),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Extend each operand as the operation reads it, then take the requested word
    function automatic logic [OperandWidth-1:0] expectedResult(
        input mulOp_t                  mulOp,
        input logic [OperandWidth-1:0] a,
        input logic [OperandWidth-1:0] b
    );
        logic [ProductWidth-1:0] wideA;
        logic [ProductWidth-1:0] wideB;
        logic [ProductWidth-1:0] product;
        wideA = {{OperandWidth{1'b0}}, a};
        wideB = {{OperandWidth{1'b0}}, b};
        if ((mulOp == MULH || mulOp == MULHSU) && a[OperandWidth-1]) begin
            wideA[ProductWidth-1:OperandWidth] = '1;
        end
        if (mulOp == MULH && b[OperandWidth-1]) begin
            wideB[ProductWidth-1:OperandWidth] = '1;
        end
        product = wideA * wideB;  // Modulo 2^64 this is the exact signed or unsigned product
        if (mulOp == MUL) begin
            return product[OperandWidth-1:0];
        end
        return product[ProductWidth-1:OperandWidth];
    endfunction

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Scoreboard sampled on the falling edge where inputs and outputs are settled
    always @(negedge clk) begin
        logic [OperandWidth-1:0] expected;
        int                      issued;
        string                   desc;
        if (start === 1'b1) begin
            expQueue.push_back(expectedResult(op, op1, op2));
            issueQueue.push_back(cycle);
            descQueue.push_back($sformatf("%s %h * %h", op.name(), op1, op2));
        end
        if (done === 1'b1) begin
            assert (expQueue.size() != 0)
                else failRun("done was strobed with no operation outstanding");
            expected = expQueue.pop_front();
            issued   = issueQueue.pop_front();
            desc     = descQueue.pop_front();
            assert (cycle - issued == latency)
                else failRun($sformatf("mismatch at %0t: %s done after %0d cycles, expected %0d",
                                       $time, desc, cycle - issued, latency));
            assert (result === expected)
                else failRun($sformatf("mismatch at %0t: %s gave %h, expected %h",
                                       $time, desc, result, expected));
        end
    end

    // Called and returning 1 ns after a rising edge
    task automatic issueOp(
        input mulOp_t                  mulOp,
        input logic [OperandWidth-1:0] a,
        input logic [OperandWidth-1:0] b
    );
        start = 1'b1;
        op    = mulOp;
        op1   = a;
        op2   = b;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expQueue.size() != 0 && waited < drainLimit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (expQueue.size() == 0)
            else failRun($sformatf("%0d expected results never arrived", expQueue.size()));
    endtask

    task automatic verifyResetState();
        reset = 1'b1;
        start = 1'b0;
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            assert (done === 1'b0)
                else failRun("done was not low while reset was held");
        end
        reset = 1'b0;
        repeat (quietCycles) begin
            @(posedge clk);
            #1;
            assert (done === 1'b0)
                else failRun("done went high after reset with no start issued");
        end
    endtask

    // Every corner pair, then random pairs, all on one operation
    task automatic runProductSet(input mulOp_t mulOp);
        logic [OperandWidth-1:0] a;
        logic [OperandWidth-1:0] b;
        for (int i = 0; i < numCorners; i++) begin
            for (int j = 0; j < numCorners; j++) begin
                issueOp(mulOp, corners[i], corners[j]);
            end
        end
        for (int k = 0; k < randomPairs; k++) begin
            a = nextRand();
            b = nextRand();
            issueOp(mulOp, a, b);
        end
        waitDrain();
    endtask

    task automatic mulLowWords();
        runProductSet(MUL);
    endtask

    task automatic mulhSignedWords();
        runProductSet(MULH);  // Corners cover -2^31 * -2^31 and -1 * 1
    endtask

    task automatic mixedSignHighWords();
        logic [OperandWidth-1:0] a;
        logic [OperandWidth-1:0] b;
        for (int i = 0; i < numMixed; i++) begin
            for (int j = 0; j < numMixed; j++) begin
                issueOp(MULHSU, negOperands[i], bigOperands[j]);
                issueOp(MULHU, negOperands[i], bigOperands[j]);
            end
        end
        for (int k = 0; k < mixedRandom; k++) begin
            a = nextRand() | 32'h80000000;
            b = nextRand() | 32'h80000000;
            issueOp(MULHSU, a, b);
            issueOp(MULHU, a, b);
        end
        waitDrain();
    endtask

    task automatic streamBackToBack();
        logic [31:0]             r;
        logic [OperandWidth-1:0] a;
        logic [OperandWidth-1:0] b;
        for (int k = 0; k < streamOps; k++) begin
            r = nextRand();
            a = nextRand();
            b = nextRand();
            issueOp(mulOp_t'(r[31:30]), a, b);
        end
        for (int k = 0; k < gapOps; k++) begin
            r = nextRand();
            a = nextRand();
            b = nextRand();
            issueOp(mulOp_t'(r[31:30]), a, b);
            idleCycles(k % 3);
        end
        waitDrain();
        idleCycles(tailCycles);
    endtask

    initial begin
        reset    = 1'b1;
        start    = 1'b0;
        op       = MUL;
        op1      = '0;
        op2      = '0;
        lcgState = lcgSeed;
        verifyResetState();
        mulLowWords();
        mulhSignedWords();
        mixedSignHighWords();
        streamBackToBack();
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        failRun($sformatf("timeout after %0d cycles, the tests did not finish", watchdogCycles));
    end

endmodule

/* build.f */
logic/mulPkg.sv
logic/operandPrep.sv
logic/wallaceTree.sv
logic/lookaheadAdder.sv
logic/productFixup.sv
logic/mulControl.sv
logic/mulUnit.sv
verif/mulUnitTb.sv

/* Makefile */
# Verilator flow for the pipelined multiply unit

VERILATOR   ?= verilator
FILELIST    ?= build.f
TOP         ?= mulUnitTb
GROUP_WIDTH ?= 4
OBJ_DIR     ?= obj_dir
LINT_FLAGS  ?= -Wall --timing
SIM_FLAGS   ?= --timing --assert
PASS_TEXT   ?= TEST OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(SIM_FLAGS) -GgroupWidth=$(GROUP_WIDTH) \
		-f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The exit status comes from the search for the pass line
sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
